//--- verilog/ex_pkg.sv
package ex_pkg;

    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int shamt_w    = 5;

    typedef logic [word_w-1:0]     word_t;
    typedef logic [2*word_w-1:0]   dword_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    localparam word_t zero_word = '0;

    // operation codes, kept close to the decoder's encoding
    typedef enum logic [7:0] {
        ALU_NOP   = 8'b0000_0000,
        // logic
        ALU_AND   = 8'b0010_0100,
        ALU_OR    = 8'b0010_0101,
        ALU_XOR   = 8'b0010_0110,
        ALU_NOR   = 8'b0010_0111,
        // shift
        ALU_SLL   = 8'b0111_1100,
        ALU_SRL   = 8'b0000_0010,
        ALU_SRA   = 8'b0000_0011,
        // arithmetic
        ALU_SLT   = 8'b0010_1010,
        ALU_SLTU  = 8'b0010_1011,
        ALU_ADD   = 8'b0010_0000,
        ALU_ADDU  = 8'b0010_0001,
        ALU_SUB   = 8'b0010_0010,
        ALU_SUBU  = 8'b0010_0011,
        ALU_ADDI  = 8'b0101_0101,
        ALU_ADDIU = 8'b0101_0110,
        ALU_CLZ   = 8'b1011_0000,
        ALU_CLO   = 8'b1011_0001,
        // multiply
        ALU_MULT  = 8'b0001_1000,
        ALU_MULTU = 8'b0001_1001,
        ALU_MUL   = 8'b1010_1001,
        // hi/lo moves
        ALU_MFHI  = 8'b0001_0000,
        ALU_MTHI  = 8'b0001_0001,
        ALU_MFLO  = 8'b0001_0010,
        ALU_MTLO  = 8'b0001_0011
    } alu_op_e;

    // result class, picks the register-file write data
    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011,
        SEL_ARITH = 3'b100,
        SEL_MUL   = 3'b101
    } alu_sel_e;

endpackage

//--- verilog/ex_if.sv
// ID/EX register contents, hi/lo already forwarded
interface ex_op_if;

    ex_pkg::alu_op_e   alu_op;
    ex_pkg::alu_sel_e  alu_sel;
    ex_pkg::word_t     operand_1;
    ex_pkg::word_t     operand_2;
    ex_pkg::reg_addr_t reg_write_addr;
    logic              reg_write_en;
    ex_pkg::word_t     hi;
    ex_pkg::word_t     lo;

    modport issue (
        output alu_op, alu_sel, operand_1, operand_2,
        output reg_write_addr, reg_write_en, hi, lo
    );

    modport exec (
        input alu_op, alu_sel, operand_1, operand_2,
        input reg_write_addr, reg_write_en, hi, lo
    );

endinterface

// per-unit results of the execute stage
interface ex_result_if;

    ex_pkg::word_t  logic_shift_out;
    ex_pkg::word_t  arith_out;
    logic           overflow;
    ex_pkg::dword_t product;

    modport logic_shift (output logic_shift_out);
    modport arith (output arith_out, overflow);
    modport mul (output product);
    modport sink (input logic_shift_out, arith_out, overflow, product);

endinterface

//--- verilog/ex_issue.sv
module ex_issue (
    input  logic              clk,
    input  logic              reset_i,
    input  ex_pkg::alu_op_e   alu_op_i,
    input  ex_pkg::alu_sel_e  alu_sel_i,
    input  ex_pkg::word_t     operand_1_i,
    input  ex_pkg::word_t     operand_2_i,
    input  ex_pkg::reg_addr_t reg_write_addr_i,
    input  logic              reg_write_en_i,
    input  ex_pkg::word_t     hi_read_data_i,
    input  ex_pkg::word_t     lo_read_data_i,
    input  ex_pkg::word_t     mem_hi_write_data_i,
    input  ex_pkg::word_t     mem_lo_write_data_i,
    input  logic              mem_hilo_write_en_i,
    input  ex_pkg::word_t     wb_hi_write_data_i,
    input  ex_pkg::word_t     wb_lo_write_data_i,
    input  logic              wb_hilo_write_en_i,
    ex_op_if.issue            op
);
    import ex_pkg::*;

    word_t hi_fwd;
    word_t lo_fwd;

    // mem beats wb, wb beats the register file
    always_comb begin
        if (mem_hilo_write_en_i) begin
            hi_fwd = mem_hi_write_data_i;
            lo_fwd = mem_lo_write_data_i;
        end else if (wb_hilo_write_en_i) begin
            hi_fwd = wb_hi_write_data_i;
            lo_fwd = wb_lo_write_data_i;
        end else begin
            hi_fwd = hi_read_data_i;
            lo_fwd = lo_read_data_i;
        end
    end

    // control half of ID/EX, clears to a bubble
    always_ff @(posedge clk) begin
        if (reset_i) begin
            op.alu_op         <= ALU_NOP;
            op.alu_sel        <= SEL_NOP;
            op.reg_write_addr <= '0;
            op.reg_write_en   <= 1'b0;
        end else begin
            op.alu_op         <= alu_op_i;
            op.alu_sel        <= alu_sel_i;
            op.reg_write_addr <= reg_write_addr_i;
            op.reg_write_en   <= reg_write_en_i;
        end
    end

    // payload half
    always_ff @(posedge clk) begin
        op.operand_1 <= operand_1_i;
        op.operand_2 <= operand_2_i;
        op.hi        <= hi_fwd;
        op.lo        <= lo_fwd;
    end

    fwd_en_known: assert property (@(posedge clk) disable iff (reset_i)
        !$isunknown({mem_hilo_write_en_i, wb_hilo_write_en_i}));

endmodule

//--- verilog/alu_logic_shift.sv
module alu_logic_shift (
    ex_op_if.exec           op,
    ex_result_if.logic_shift res
);
    import ex_pkg::*;

    logic [shamt_w-1:0] shamt;
    word_t              result;

    // shift amount comes from operand 1
    assign shamt = op.operand_1[shamt_w-1:0];

    always_comb begin
        case (op.alu_op)
            ALU_OR: begin
                result = op.operand_1 | op.operand_2;
            end
            ALU_AND: begin
                result = op.operand_1 & op.operand_2;
            end
            ALU_NOR: begin
                result = ~(op.operand_1 | op.operand_2);
            end
            ALU_XOR: begin
                result = op.operand_1 ^ op.operand_2;
            end
            ALU_SLL: begin
                result = op.operand_2 << shamt;
            end
            ALU_SRL: begin
                result = op.operand_2 >> shamt;
            end
            ALU_SRA: begin
                // sign fill
                result = word_t'($signed(op.operand_2) >>> shamt);
            end
            default: begin
                result = zero_word;
            end
        endcase
    end

    assign res.logic_shift_out = result;

endmodule

//--- verilog/alu_arith.sv
module alu_arith (
    ex_op_if.exec     op,
    ex_result_if.arith res
);
    import ex_pkg::*;

    logic                    is_sub;
    word_t                   operand_2_mux;
    word_t                   sum;
    logic                    a_sign;
    logic                    b_sign;
    logic                    s_sign;
    logic                    less_than;
    word_t                   count_src;
    logic [$clog2(word_w):0] lead_count;
    word_t                   result;

    assign is_sub = op.alu_op inside {ALU_SUB, ALU_SUBU, ALU_SLT};

    // subtract by adding the two's complement
    assign operand_2_mux = is_sub ? (~op.operand_2 + word_t'(1)) : op.operand_2;
    assign sum = op.operand_1 + operand_2_mux;

    assign a_sign = op.operand_1[word_w-1];
    assign b_sign = op.operand_2[word_w-1];
    assign s_sign = sum[word_w-1];

    // effective operand 2 sign flips on subtract
    assign res.overflow = (a_sign == (b_sign ^ is_sub)) && (s_sign != a_sign);

    // signed compare uses the difference sign when signs agree
    always_comb begin
        if (op.alu_op == ALU_SLT) begin
            less_than = (a_sign && !b_sign) || (a_sign == b_sign && s_sign);
        end else begin
            less_than = op.operand_1 < op.operand_2;
        end
    end

    // clo is clz on the inverted word
    always_comb begin
        count_src  = (op.alu_op == ALU_CLO) ? ~op.operand_1 : op.operand_1;
        lead_count = ($clog2(word_w)+1)'(word_w);
        for (int i = 0; i < word_w; i++) begin
            if (count_src[i]) begin
                lead_count = ($clog2(word_w)+1)'(word_w - 1 - i);
            end
        end
    end

    always_comb begin
        case (op.alu_op)
            ALU_SLT, ALU_SLTU: begin
                result = word_t'(less_than);
            end
            ALU_ADD, ALU_ADDU, ALU_ADDI, ALU_ADDIU, ALU_SUB, ALU_SUBU: begin
                result = sum;
            end
            ALU_CLZ, ALU_CLO: begin
                result = word_t'(lead_count);
            end
            default: begin
                result = zero_word;
            end
        endcase
    end

    assign res.arith_out = result;

endmodule

//--- verilog/alu_mul.sv
module alu_mul (
    ex_op_if.exec    op,
    ex_result_if.mul res
);
    import ex_pkg::*;

    logic   is_signed;
    logic   negate;
    word_t  mcand;
    word_t  mplier;
    dword_t raw_product;

    assign is_signed = op.alu_op inside {ALU_MUL, ALU_MULT};

    // magnitudes for the signed forms
    assign mcand  = (is_signed && op.operand_1[word_w-1]) ? (~op.operand_1 + word_t'(1))
                                                          : op.operand_1;
    assign mplier = (is_signed && op.operand_2[word_w-1]) ? (~op.operand_2 + word_t'(1))
                                                          : op.operand_2;

    assign raw_product = dword_t'(mcand) * dword_t'(mplier);

    // result negative only when the signs differ
    assign negate = is_signed && (op.operand_1[word_w-1] ^ op.operand_2[word_w-1]);

    assign res.product = negate ? (~raw_product + dword_t'(1)) : raw_product;

endmodule

//--- verilog/ex_writeback_select.sv
module ex_writeback_select (
    input  logic              clk,
    input  logic              reset_i,
    ex_op_if.exec             op,
    ex_result_if.sink         res,
    output ex_pkg::word_t     reg_write_data_o,
    output ex_pkg::reg_addr_t reg_write_addr_o,
    output logic              reg_write_en_o,
    output ex_pkg::word_t     hi_write_data_o,
    output ex_pkg::word_t     lo_write_data_o,
    output logic              hilo_write_en_o
);
    import ex_pkg::*;

    word_t reg_data_d;
    logic  reg_en_d;
    logic  ovf_trap;
    word_t hi_d;
    word_t lo_d;
    logic  hilo_en_d;

    // trapping adds drop the write on overflow
    assign ovf_trap = (op.alu_op inside {ALU_ADD, ALU_ADDI, ALU_SUB}) && res.overflow;
    assign reg_en_d = op.reg_write_en && !ovf_trap;

    always_comb begin
        case (op.alu_sel)
            SEL_LOGIC, SEL_SHIFT: begin
                reg_data_d = res.logic_shift_out;
            end
            SEL_ARITH: begin
                reg_data_d = res.arith_out;
            end
            SEL_MOVE: begin
                if (op.alu_op == ALU_MFHI) begin
                    reg_data_d = op.hi;
                end else if (op.alu_op == ALU_MFLO) begin
                    reg_data_d = op.lo;
                end else begin
                    reg_data_d = zero_word;
                end
            end
            SEL_MUL: begin
                reg_data_d = res.product[word_w-1:0];
            end
            default: begin
                reg_data_d = zero_word;
            end
        endcase
    end

    // hi/lo write request; mthi/mtlo keep the other half
    always_comb begin
        hilo_en_d = 1'b1;
        case (op.alu_op)
            ALU_MULT, ALU_MULTU: begin
                hi_d = res.product[2*word_w-1:word_w];
                lo_d = res.product[word_w-1:0];
            end
            ALU_MTHI: begin
                hi_d = op.operand_1;
                lo_d = op.lo;
            end
            ALU_MTLO: begin
                hi_d = op.hi;
                lo_d = op.operand_1;
            end
            default: begin
                hilo_en_d = 1'b0;
                hi_d      = zero_word;
                lo_d      = zero_word;
            end
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            reg_write_data_o <= zero_word;
            reg_write_addr_o <= '0;
            reg_write_en_o   <= 1'b0;
            hi_write_data_o  <= zero_word;
            lo_write_data_o  <= zero_word;
            hilo_write_en_o  <= 1'b0;
        end else begin
            reg_write_data_o <= reg_data_d;
            reg_write_addr_o <= op.reg_write_addr;
            reg_write_en_o   <= reg_en_d;
            hi_write_data_o  <= hi_d;
            lo_write_data_o  <= lo_d;
            hilo_write_en_o  <= hilo_en_d;
        end
    end

    hilo_only_hilo_ops: assert property (@(posedge clk) disable iff (reset_i)
        hilo_write_en_o |-> $past(op.alu_sel) inside {SEL_MUL, SEL_MOVE});

endmodule

//--- verilog/ex_stage.sv
module ex_stage (
    input  logic              clk,
    input  logic              reset_i,
    input  ex_pkg::alu_op_e   alu_op_i,
    input  ex_pkg::alu_sel_e  alu_sel_i,
    input  ex_pkg::word_t     operand_1_i,
    input  ex_pkg::word_t     operand_2_i,
    input  ex_pkg::reg_addr_t reg_write_addr_i,
    input  logic              reg_write_en_i,
    input  ex_pkg::word_t     hi_read_data_i,
    input  ex_pkg::word_t     lo_read_data_i,
    input  ex_pkg::word_t     mem_hi_write_data_i,
    input  ex_pkg::word_t     mem_lo_write_data_i,
    input  logic              mem_hilo_write_en_i,
    input  ex_pkg::word_t     wb_hi_write_data_i,
    input  ex_pkg::word_t     wb_lo_write_data_i,
    input  logic              wb_hilo_write_en_i,
    output ex_pkg::word_t     reg_write_data_o,
    output ex_pkg::reg_addr_t reg_write_addr_o,
    output logic              reg_write_en_o,
    output ex_pkg::word_t     hi_write_data_o,
    output ex_pkg::word_t     lo_write_data_o,
    output logic              hilo_write_en_o
);
    import ex_pkg::*;

    ex_op_if     op_bus ();
    ex_result_if res_bus ();

    ex_issue u_issue (
        .clk                 (clk),
        .reset_i             (reset_i),
        .alu_op_i            (alu_op_i),
        .alu_sel_i           (alu_sel_i),
        .operand_1_i         (operand_1_i),
        .operand_2_i         (operand_2_i),
        .reg_write_addr_i    (reg_write_addr_i),
        .reg_write_en_i      (reg_write_en_i),
        .hi_read_data_i      (hi_read_data_i),
        .lo_read_data_i      (lo_read_data_i),
        .mem_hi_write_data_i (mem_hi_write_data_i),
        .mem_lo_write_data_i (mem_lo_write_data_i),
        .mem_hilo_write_en_i (mem_hilo_write_en_i),
        .wb_hi_write_data_i  (wb_hi_write_data_i),
        .wb_lo_write_data_i  (wb_lo_write_data_i),
        .wb_hilo_write_en_i  (wb_hilo_write_en_i),
        .op                  (op_bus.issue)
    );

    alu_logic_shift u_logic_shift (
        .op  (op_bus.exec),
        .res (res_bus.logic_shift)
    );

    alu_arith u_arith (
        .op  (op_bus.exec),
        .res (res_bus.arith)
    );

    alu_mul u_mul (
        .op  (op_bus.exec),
        .res (res_bus.mul)
    );

    ex_writeback_select u_wb_select (
        .clk              (clk),
        .reset_i          (reset_i),
        .op               (op_bus.exec),
        .res              (res_bus.sink),
        .reg_write_data_o (reg_write_data_o),
        .reg_write_addr_o (reg_write_addr_o),
        .reg_write_en_o   (reg_write_en_o),
        .hi_write_data_o  (hi_write_data_o),
        .lo_write_data_o  (lo_write_data_o),
        .hilo_write_en_o  (hilo_write_en_o)
    );

endmodule

//--- bench/ex_ref_model.svh
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// mem first, then wb, then the register file
function automatic dword_t fwd_hilo(input logic mem_en, input logic wb_en,
                                    input word_t mem_hi, input word_t mem_lo,
                                    input word_t wb_hi, input word_t wb_lo,
                                    input word_t rf_hi, input word_t rf_lo);
    if (mem_en) begin
        return {mem_hi, mem_lo};
    end
    if (wb_en) begin
        return {wb_hi, wb_lo};
    end
    return {rf_hi, rf_lo};
endfunction

function automatic word_t ref_logic_shift(input alu_op_e op, input word_t a, input word_t b);
    int    sh;
    word_t r;
    sh = a[4:0];
    case (op)
        ALU_OR:  return a | b;
        ALU_AND: return a & b;
        ALU_NOR: return ~(a | b);
        ALU_XOR: return a ^ b;
        ALU_SLL: return b << sh;
        ALU_SRL: return b >> sh;
        ALU_SRA: begin
            r = b >> sh;
            if (b[word_w-1]) begin
                r = r | ~(32'hffff_ffff >> sh);
            end
            return r;
        end
        default: return zero_word;
    endcase
endfunction

function automatic word_t ref_lead(input word_t a, input logic ones);
    int n;
    n = 0;
    while (n < word_w && a[word_w-1-n] == ones) begin
        n++;
    end
    return word_t'(n);
endfunction

function automatic word_t ref_arith(input alu_op_e op, input word_t a, input word_t b,
                                    output logic ovf);
    longint sa;
    longint sb;
    longint wide;
    sa   = longint'($signed(a));
    sb   = longint'($signed(b));
    wide = (op inside {ALU_SUB, ALU_SUBU}) ? sa - sb : sa + sb;
    ovf  = (wide > longint'(32'sh7fff_ffff)) || (wide < longint'(32'sh8000_0000));
    case (op)
        ALU_ADD, ALU_ADDU, ALU_ADDI, ALU_ADDIU, ALU_SUB, ALU_SUBU: return wide[31:0];
        ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
        ALU_CLZ:  return ref_lead(a, 1'b0);
        ALU_CLO:  return ref_lead(a, 1'b1);
        default:  return zero_word;
    endcase
endfunction

function automatic dword_t ref_product(input alu_op_e op, input word_t a, input word_t b);
    longint          sa;
    longint          sb;
    longint unsigned ua;
    longint unsigned ub;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    ua = a;
    ub = b;
    if (op == ALU_MULTU) begin
        return dword_t'(ua * ub);
    end
    return dword_t'(sa * sb);
endfunction

function automatic void ref_outputs(input alu_op_e op, input alu_sel_e sel,
                                    input word_t a, input word_t b, input logic en,
                                    input dword_t hilo,
                                    output word_t rd, output logic ren,
                                    output word_t hi_o, output word_t lo_o,
                                    output logic hen);
    word_t  ls;
    word_t  ar;
    logic   ovf;
    dword_t prod;
    ls   = ref_logic_shift(op, a, b);
    ar   = ref_arith(op, a, b, ovf);
    prod = ref_product(op, a, b);
    case (sel)
        SEL_LOGIC, SEL_SHIFT: rd = ls;
        SEL_ARITH:            rd = ar;
        SEL_MUL:              rd = prod[31:0];
        SEL_MOVE: begin
            rd = (op == ALU_MFHI) ? hilo[63:32] : (op == ALU_MFLO) ? hilo[31:0] : zero_word;
        end
        default:              rd = zero_word;
    endcase
    ren = en && !((op inside {ALU_ADD, ALU_ADDI, ALU_SUB}) && ovf);
    hen = 1'b1;
    case (op)
        ALU_MULT, ALU_MULTU: {hi_o, lo_o} = prod;
        ALU_MTHI:            {hi_o, lo_o} = {a, hilo[31:0]};
        ALU_MTLO:            {hi_o, lo_o} = {hilo[63:32], a};
        default: begin
            hen  = 1'b0;
            hi_o = zero_word;
            lo_o = zero_word;
        end
    endcase
endfunction

`endif

//--- bench/ex_stage_tb.sv
module ex_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import ex_pkg::*;

    `include "ex_ref_model.svh"

    localparam int num_instr    = 3000;
    localparam int idle_timeout = 10;
    localparam int drain_limit  = 10;

    typedef struct {
        word_t     rd;
        reg_addr_t ra;
        logic      ren;
        word_t     hi;
        word_t     lo;
        logic      hen;
        int        due;
    } expect_t;

    logic      clk;
    logic      reset_i;
    alu_op_e   alu_op_i;
    alu_sel_e  alu_sel_i;
    word_t     operand_1_i;
    word_t     operand_2_i;
    reg_addr_t reg_write_addr_i;
    logic      reg_write_en_i;
    word_t     hi_read_data_i;
    word_t     lo_read_data_i;
    word_t     mem_hi_write_data_i;
    word_t     mem_lo_write_data_i;
    logic      mem_hilo_write_en_i;
    word_t     wb_hi_write_data_i;
    word_t     wb_lo_write_data_i;
    logic      wb_hilo_write_en_i;
    word_t     reg_write_data_o;
    reg_addr_t reg_write_addr_o;
    logic      reg_write_en_o;
    word_t     hi_write_data_o;
    word_t     lo_write_data_o;
    logic      hilo_write_en_o;

    integer  seed;
    int      cycle;
    int      reg_errors;
    int      hilo_errors;
    logic    timed_out;
    expect_t exp_q[$];

    alu_op_e op_pool [24] = '{ALU_OR, ALU_AND, ALU_NOR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
                              ALU_ADD, ALU_ADDU, ALU_ADDI, ALU_ADDIU, ALU_SUB, ALU_SUBU,
                              ALU_SLT, ALU_SLTU, ALU_CLZ, ALU_CLO, ALU_MUL, ALU_MULT,
                              ALU_MULTU, ALU_MFHI, ALU_MFLO, ALU_MTHI, ALU_MTLO};

    ex_stage u_dut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic check_reg(input word_t data, input reg_addr_t addr, input logic en);
        if (reg_write_data_o !== data || reg_write_addr_o !== addr || reg_write_en_o !== en) begin
            reg_errors++;
            $display("ERR %0t: reg write got %h/%0d/%b, expected %h/%0d/%b", $time,
                     reg_write_data_o, reg_write_addr_o, reg_write_en_o, data, addr, en);
        end
    endtask

    task automatic check_hilo(input word_t hi, input word_t lo, input logic en);
        if (hi_write_data_o !== hi || lo_write_data_o !== lo || hilo_write_en_o !== en) begin
            hilo_errors++;
            $display("ERR %0t: hilo write got %h/%h/%b, expected %h/%h/%b", $time,
                     hi_write_data_o, lo_write_data_o, hilo_write_en_o, hi, lo, en);
        end
    endtask

    function automatic alu_sel_e sel_for_op(input alu_op_e op);
        case (op)
            ALU_OR, ALU_AND, ALU_NOR, ALU_XOR:      return SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:              return SEL_SHIFT;
            ALU_MUL, ALU_MULT, ALU_MULTU:           return SEL_MUL;
            ALU_MFHI, ALU_MFLO, ALU_MTHI, ALU_MTLO: return SEL_MOVE;
            ALU_NOP:                                return SEL_NOP;
            default:                                return SEL_ARITH;
        endcase
    endfunction

    // values close to the sign boundary make overflow common
    function automatic word_t boundary_word();
        word_t r;
        r = $random(seed);
        case (r[6:4])
            3'd0:    return 32'h7fff_fff0 + r[3:0];
            3'd1:    return 32'h8000_0000 + r[3:0];
            3'd2:    return 32'h8000_0000;
            3'd3:    return {{28{r[31]}}, r[3:0]};
            default: return $random(seed);
        endcase
    endfunction

    function automatic word_t count_word();
        word_t r;
        r = $random(seed);
        case (r[7:5])
            3'd0:    return zero_word;
            3'd1:    return 32'hffff_ffff;
            3'd2:    return 32'h1 << r[4:0];
            3'd3:    return ~(32'h1 << r[4:0]);
            default: return $random(seed);
        endcase
    endfunction

    task automatic drive_idle();
        alu_op_i            = ALU_NOP;
        alu_sel_i           = SEL_NOP;
        operand_1_i         = zero_word;
        operand_2_i         = zero_word;
        reg_write_addr_i    = '0;
        reg_write_en_i      = 1'b0;
        hi_read_data_i      = zero_word;
        lo_read_data_i      = zero_word;
        mem_hi_write_data_i = zero_word;
        mem_lo_write_data_i = zero_word;
        mem_hilo_write_en_i = 1'b0;
        wb_hi_write_data_i  = zero_word;
        wb_lo_write_data_i  = zero_word;
        wb_hilo_write_en_i  = 1'b0;
    endtask

    // drives one instruction with random hi/lo sources and queues its expectation
    task automatic issue_instr(input alu_op_e op, input word_t a, input word_t b,
                               input logic en, input reg_addr_t ra);
        expect_t e;
        dword_t  hilo;
        word_t   r;
        r                   = $random(seed);
        alu_op_i            = op;
        alu_sel_i           = sel_for_op(op);
        operand_1_i         = a;
        operand_2_i         = b;
        reg_write_en_i      = en;
        reg_write_addr_i    = ra;
        hi_read_data_i      = $random(seed);
        lo_read_data_i      = $random(seed);
        mem_hi_write_data_i = $random(seed);
        mem_lo_write_data_i = $random(seed);
        wb_hi_write_data_i  = $random(seed);
        wb_lo_write_data_i  = $random(seed);
        mem_hilo_write_en_i = r[0];
        wb_hilo_write_en_i  = r[1];
        hilo = fwd_hilo(r[0], r[1], mem_hi_write_data_i, mem_lo_write_data_i,
                        wb_hi_write_data_i, wb_lo_write_data_i,
                        hi_read_data_i, lo_read_data_i);
        ref_outputs(op, sel_for_op(op), a, b, en, hilo, e.rd, e.ren, e.hi, e.lo, e.hen);
        e.ra  = ra;
        e.due = cycle + 2;
        exp_q.push_back(e);
    endtask

    task automatic random_instr();
        alu_op_e op;
        word_t   r;
        word_t   a;
        word_t   b;
        logic    en;
        r  = $random(seed);
        op = op_pool[r[31:8] % 24];
        en = (r[5:3] != 3'd0);
        a  = $random(seed);
        b  = $random(seed);
        case (sel_for_op(op))
            SEL_SHIFT: begin
                // amounts 0 and 31 get extra weight
                if (r[7:6] == 2'd0) begin
                    a[4:0] = 5'd0;
                end else if (r[7:6] == 2'd1) begin
                    a[4:0] = 5'd31;
                end
            end
            SEL_ARITH: begin
                if (op inside {ALU_CLZ, ALU_CLO}) begin
                    a = count_word();
                end else begin
                    a = boundary_word();
                    b = boundary_word();
                end
            end
            SEL_MUL: begin
                if (r[6]) begin
                    a = boundary_word();
                    b = boundary_word();
                end
            end
            default: begin
            end
        endcase
        if (op inside {ALU_MULT, ALU_MULTU, ALU_MTHI, ALU_MTLO}) begin
            en = 1'b0;
        end
        if (r[2:0] == 3'd0) begin
            issue_instr(ALU_NOP, zero_word, zero_word, 1'b0, '0);
        end else begin
            issue_instr(op, a, b, en, reg_addr_t'($random(seed)));
        end
    endtask

    task automatic next_cycle();
        expect_t e;
        @(posedge clk);
        #2;
        cycle++;
        if (exp_q.size() > 0 && exp_q[0].due == cycle) begin
            e = exp_q.pop_front();
            check_reg(e.rd, e.ra, e.ren);
            check_hilo(e.hi, e.lo, e.hen);
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while ((reg_write_en_o !== 1'b0 || hilo_write_en_o !== 1'b0) && waited < idle_timeout) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (reg_write_en_o !== 1'b0 || hilo_write_en_o !== 1'b0) begin
            timed_out = 1'b1;
            $display("timed out: the write enables never went low after reset");
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < drain_limit) begin
            next_cycle();
            drive_idle();
            waited++;
        end
        if (exp_q.size() > 0) begin
            timed_out = 1'b1;
            $display("timed out: %0d expected results never appeared", exp_q.size());
        end
    endtask

    initial begin
        seed        = 32'h85ec2ccb;
        cycle       = 0;
        reg_errors  = 0;
        hilo_errors = 0;
        timed_out   = 1'b0;
        reset_i     = 1'b1;
        drive_idle();
        repeat (3) @(posedge clk);
        #2;
        reset_i = 1'b0;
        wait_idle();
        if (!timed_out) begin
            check_reg(zero_word, '0, 1'b0);
            check_hilo(zero_word, zero_word, 1'b0);
            for (int i = 0; i < num_instr; i++) begin
                next_cycle();
                random_instr();
            end
            drain();
        end
        $display("errors: reg %0d, hilo %0d, timeout %0d", reg_errors, hilo_errors, timed_out);
        if (reg_errors == 0 && hilo_errors == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- ex_stage.f
+incdir+bench
verilog/ex_pkg.sv
verilog/ex_if.sv
verilog/ex_issue.sv
verilog/alu_logic_shift.sv
verilog/alu_arith.sv
verilog/alu_mul.sv
verilog/ex_writeback_select.sv
verilog/ex_stage.sv
bench/ex_stage_tb.sv

//--- Bender.yml
package:
  name: ex_stage

sources:
  - verilog/ex_pkg.sv
  - verilog/ex_if.sv
  - verilog/ex_issue.sv
  - verilog/alu_logic_shift.sv
  - verilog/alu_arith.sv
  - verilog/alu_mul.sv
  - verilog/ex_writeback_select.sv
  - verilog/ex_stage.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/ex_stage_tb.sv
